/* simd_unit_top.f */
hdl/simd_pkg.sv
hdl/vec_config_regs.sv
hdl/latency_pipe.sv
hdl/simd_issue_decode.sv
hdl/simd_alu.sv
hdl/simd_mul.sv
hdl/simd_writeback.sv
hdl/simd_unit_top.sv
testbench/simd_unit_assert.sv
testbench/simd_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run the testbench, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module simd_unit_tb -f simd_unit_top.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vsimd_unit_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/simd_unit_tb.sv */
// Testbench for the vector unit with stimulus, expected-value model and completion checks
`timescale 1ns/1ns
`default_nettype none

module simd_unit_tb;

    typedef struct packed {
        int unsigned        due;     // Cycle count at which the output valid is seen
        logic               scalar;
        simd_pkg::reg_idx_t dest;
        simd_pkg::vreg_t    data;
    } exp_t;

    logic                clk_i;
    logic                rstn_i;
    logic                cfg_we;
    simd_pkg::avl_t      cfg_avl;
    simd_pkg::sew_t      cfg_sew;
    logic                issue_valid;
    simd_pkg::op_t       op;
    simd_pkg::src_t      src;
    logic                use_mask;
    simd_pkg::reg_idx_t  dest;
    simd_pkg::vreg_t     vs1;
    simd_pkg::vreg_t     vs2;
    simd_pkg::vreg_t     old_vd;
    simd_pkg::mask_t     mask;
    simd_pkg::xlen_t     rs1;
    logic [4:0]          imm;
    logic                vec_valid;
    logic                scalar_valid;
    simd_pkg::reg_idx_t  wb_dest;
    simd_pkg::vreg_t     vec_data;
    simd_pkg::xlen_t     scalar_data;
    logic                assert_fault;

    int          seed;
    int unsigned cyc;
    int          cur_sew;    // Model copy of the config registers
    int          cur_vl;
    exp_t        exp_q[$];

    simd_unit_top #(
        .MUL_STAGES_NARROW (2),
        .MUL_STAGES_WIDE   (3)
    ) u_simd_unit_top (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .cfg_we_i       (cfg_we),
        .cfg_avl_i      (cfg_avl),
        .cfg_sew_i      (cfg_sew),
        .issue_valid_i  (issue_valid),
        .op_i           (op),
        .src_i          (src),
        .use_mask_i     (use_mask),
        .dest_i         (dest),
        .vs1_i          (vs1),
        .vs2_i          (vs2),
        .old_vd_i       (old_vd),
        .mask_i         (mask),
        .rs1_i          (rs1),
        .imm_i          (imm),
        .vec_valid_o    (vec_valid),
        .scalar_valid_o (scalar_valid),
        .wb_dest_o      (wb_dest),
        .vec_data_o     (vec_data),
        .scalar_data_o  (scalar_data)
    );

    assign assert_fault = u_simd_unit_top.u_simd_unit_assert.fault_rst
                        | u_simd_unit_top.u_simd_unit_assert.fault_excl
                        | u_simd_unit_top.u_simd_unit_assert.fault_pipe
                        | u_simd_unit_top.u_simd_unit_assert.fault_vl;

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic longint unsigned lo_mask(input int w);
        return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    endfunction

    function automatic longint unsigned get_elem(input simd_pkg::vreg_t v, input int e,
                                                 input int w);
        return 64'(v >> (e * w)) & lo_mask(w);
    endfunction

    // Expected element e from the stimulus now on the DUT inputs
    function automatic longint unsigned model_elem(input int e, input int w);
        longint unsigned a;
        longint unsigned b;
        longint unsigned r;
        case (src)
            simd_pkg::SRC_VV: a = get_elem(vs1, e, w);
            simd_pkg::SRC_VX: a = rs1;
            default:          a = {{59{imm[4]}}, imm};
        endcase
        b = get_elem(vs2, e, w);
        case (op)
            simd_pkg::OP_VADD: r = b + a;
            simd_pkg::OP_VSUB: r = b - a;
            simd_pkg::OP_VAND: r = b & a;
            simd_pkg::OP_VOR:  r = b | a;
            simd_pkg::OP_VXOR: r = b ^ a;
            default:           r = b * a;
        endcase
        if (e >= cur_vl) begin
            r = '1;  // Tail
        end else if (use_mask && !mask[e]) begin
            r = get_elem(old_vd, e, w);
        end
        return r & lo_mask(w);
    endfunction

    function automatic simd_pkg::vreg_t model_vector();
        simd_pkg::vreg_t v;
        int              w;
        w = 8 << cur_sew;
        v = '0;
        for (int e = 0; e < simd_pkg::VLEN / w; e++) begin
            v = v | (simd_pkg::vreg_t'(model_elem(e, w)) << (e * w));
        end
        return v;
    endfunction

    function automatic simd_pkg::xlen_t model_scalar();
        longint unsigned x;
        int              w;
        w = 8 << cur_sew;
        x = get_elem(vs2, 0, w);
        if (w < 64 && x[w-1]) begin
            x = x | ~lo_mask(w);
        end
        return x;
    endfunction

    function automatic simd_pkg::vreg_t rand_vreg();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic value_error(input string name, input simd_pkg::vreg_t exp,
                               input simd_pkg::vreg_t got);
        $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic run_error(input string what);
        $display("Run stopped: %s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Compares the outputs with the oldest expected completion when it falls due
    task automatic check_completion();
        exp_t e;
        if (assert_fault) begin
            run_error("a protocol assertion on the unit failed");
        end
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            assert (vec_valid === !e.scalar)
                else value_error("vec_valid_o", !e.scalar, vec_valid);
            assert (scalar_valid === e.scalar)
                else value_error("scalar_valid_o", e.scalar, scalar_valid);
            assert (wb_dest === e.dest) else value_error("wb_dest_o", e.dest, wb_dest);
            if (e.scalar) begin
                assert (scalar_data === e.data[63:0])
                    else value_error("scalar_data_o", e.data, scalar_data);
            end else begin
                assert (vec_data === e.data) else value_error("vec_data_o", e.data, vec_data);
            end
        end else begin
            assert (!vec_valid && !scalar_valid)
                else run_error("a completion strobe came with no instruction due");
        end
    endtask

    task automatic next_cycle();
        @(negedge clk_i);
        cyc++;
        check_completion();
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            issue_valid = 1'b0;
        end
    endtask

    task automatic configure(input int sew, input int avl);
        next_cycle();
        issue_valid = 1'b0;
        cfg_we      = 1'b1;
        cfg_sew     = simd_pkg::sew_t'(sew);
        cfg_avl     = simd_pkg::avl_t'(avl);
        next_cycle();
        cfg_we  = 1'b0;
        cur_sew = sew;
        cur_vl  = (avl < simd_pkg::VLEN / (8 << sew)) ? avl : simd_pkg::VLEN / (8 << sew);
    endtask

    task automatic issue(input simd_pkg::op_t op_sel, input simd_pkg::src_t src_sel,
                         input logic masked);
        exp_t item;
        int   lat;
        next_cycle();
        issue_valid = 1'b1;
        op          = op_sel;
        src         = src_sel;
        use_mask    = masked;
        mask        = simd_pkg::mask_t'($random(seed));
        dest        = simd_pkg::reg_idx_t'($random(seed));
        vs1         = rand_vreg();
        vs2         = rand_vreg();
        old_vd      = rand_vreg();
        rs1         = {$random(seed), $random(seed)};
        imm         = 5'($random(seed));
        lat = (op != simd_pkg::OP_VMUL) ? 1 : (cur_sew == 3) ? 3 : 2;
        item.due    = cyc + lat;
        item.scalar = (op == simd_pkg::OP_VMV_X_S);
        item.dest   = dest;
        item.data   = item.scalar ? simd_pkg::vreg_t'(model_scalar()) : model_vector();
        if (item.scalar || cur_vl != 0) begin
            exp_q.push_back(item);
        end
    endtask

    // Waits for all outstanding completions, then leaves a gap before the next class
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 10) begin
                run_error("timeout waiting for outstanding completions");
            end
            idle(1);
            waited++;
        end
        idle(3);
    endtask

    initial begin
        seed        = 32'h7103;
        cyc         = 0;
        cur_sew     = 0;
        cur_vl      = 0;
        rstn_i      = 1'b0;
        cfg_we      = 1'b0;
        cfg_avl     = '0;
        cfg_sew     = simd_pkg::SEW_8;
        issue_valid = 1'b0;
        op          = simd_pkg::OP_VADD;
        src         = simd_pkg::SRC_VV;
        use_mask    = 1'b0;
        dest        = '0;
        vs1         = '0;
        vs2         = '0;
        old_vd      = '0;
        mask        = '0;
        rs1         = '0;
        imm         = '0;
        idle(8);
        rstn_i = 1'b1;

        issue(simd_pkg::OP_VADD, simd_pkg::SRC_VV, 1'b0);  // vl is 0 so no write back
        idle(3);

        for (int s = 0; s < 4; s++) begin
            configure(s, 255);
            for (int k = 0; k < 5; k++) begin
                for (int f = 0; f < 3; f++) begin
                    issue(simd_pkg::op_t'(k), simd_pkg::src_t'(f), 1'b0);
                end
            end
            drain();
        end

        // Masked ops with a clamped length, then a shorter one
        for (int s = 0; s < 4; s++) begin
            configure(s, 100 + s);
            for (int k = 0; k < 5; k++) begin
                issue(simd_pkg::op_t'(k), simd_pkg::src_t'(k % 3), 1'b1);
            end
            configure(s, 1 + ($unsigned($random(seed)) % (simd_pkg::VLEN / (8 << s) - 1)));
            for (int k = 0; k < 5; k++) begin
                issue(simd_pkg::op_t'(k), simd_pkg::src_t'((k + 1) % 3), 1'b1);
            end
            drain();
        end

        for (int s = 0; s < 4; s++) begin
            configure(s, 255);
            for (int j = 0; j < 4; j++) begin
                issue(simd_pkg::OP_VMUL, simd_pkg::src_t'(j % 3), j[0]);
            end
            drain();
        end

        for (int s = 0; s < 4; s++) begin
            configure(s, 255);
            issue(simd_pkg::OP_VMV_X_S, simd_pkg::SRC_VV, 1'b0);
            issue(simd_pkg::OP_VMV_X_S, simd_pkg::SRC_VV, 1'b0);
        end
        drain();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/simd_unit_assert.sv */
// Bound protocol assertions on output valids, pipe completions and vector length
`timescale 1ns/1ns
`default_nettype none

module simd_unit_assert (
    input logic           clk_i,
    input logic           rstn_i,
    input logic           vec_valid_i,
    input logic           scalar_valid_i,
    input logic           alu_done_i,
    input logic           narrow_done_i,
    input logic           wide_done_i,
    input simd_pkg::sew_t sew_i,
    input simd_pkg::vl_t  vl_i
);

    // Sticky fault flags, one per property
    logic fault_rst  = 1'b0;
    logic fault_excl = 1'b0;
    logic fault_pipe = 1'b0;
    logic fault_vl   = 1'b0;

    valid_low_in_reset: assert property (@(posedge clk_i)
        !rstn_i |-> !vec_valid_i && !scalar_valid_i)
        else begin
            fault_rst = 1'b1;
            $error("output valid high during reset");
        end

    one_output_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(vec_valid_i && scalar_valid_i))
        else begin
            fault_excl = 1'b1;
            $error("vector and scalar valids high together");
        end

    // Two pipes finishing together would drop a result
    one_pipe_done: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0({alu_done_i, narrow_done_i, wide_done_i}))
        else begin
            fault_pipe = 1'b1;
            $error("more than one pipe completed in a cycle");
        end

    vl_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        int'(vl_i) <= simd_pkg::VLEN / (8 << sew_i))
        else begin
            fault_vl = 1'b1;
            $error("vl above the element count for the current SEW");
        end

endmodule

bind simd_unit_top simd_unit_assert u_simd_unit_assert (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .vec_valid_i    (vec_valid_o),
    .scalar_valid_i (scalar_valid_o),
    .alu_done_i     (alu_done),
    .narrow_done_i  (narrow_done),
    .wide_done_i    (wide_done),
    .sew_i          (cfg_sew),
    .vl_i           (cfg_vl)
);

`default_nettype wire

/* hdl/simd_unit_top.sv */
// Top level of the vector unit with config, decode, functional units, pipes and writeback
`timescale 1ns/1ns
`default_nettype none

module simd_unit_top #(
    parameter int MUL_STAGES_NARROW = 2,
    parameter int MUL_STAGES_WIDE   = 3
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 cfg_we_i,
    input  simd_pkg::avl_t       cfg_avl_i,
    input  simd_pkg::sew_t       cfg_sew_i,
    input  logic                 issue_valid_i,
    input  simd_pkg::op_t        op_i,
    input  simd_pkg::src_t       src_i,
    input  logic                 use_mask_i,
    input  simd_pkg::reg_idx_t   dest_i,
    input  simd_pkg::vreg_t      vs1_i,
    input  simd_pkg::vreg_t      vs2_i,
    input  simd_pkg::vreg_t      old_vd_i,
    input  simd_pkg::mask_t      mask_i,
    input  simd_pkg::xlen_t      rs1_i,
    input  logic [4:0]           imm_i,
    output logic                 vec_valid_o,
    output logic                 scalar_valid_o,
    output simd_pkg::reg_idx_t   wb_dest_o,
    output simd_pkg::vreg_t      vec_data_o,
    output simd_pkg::xlen_t      scalar_data_o
);

    simd_pkg::sew_t      cfg_sew;
    simd_pkg::vl_t       cfg_vl;
    simd_pkg::uop_ctrl_t ctrl;
    simd_pkg::vreg_t     opa;
    simd_pkg::vreg_t     opb;
    logic                alu_valid;
    logic                mul_narrow_valid;
    logic                mul_wide_valid;
    simd_pkg::uop_t      alu_uop;
    simd_pkg::uop_t      mul_uop;
    logic                alu_done;
    logic                narrow_done;
    logic                wide_done;
    simd_pkg::uop_t      alu_done_uop;
    simd_pkg::uop_t      narrow_done_uop;
    simd_pkg::uop_t      wide_done_uop;

    vec_config_regs u_vec_config_regs (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .cfg_we_i  (cfg_we_i),
        .cfg_avl_i (cfg_avl_i),
        .cfg_sew_i (cfg_sew_i),
        .sew_o     (cfg_sew),
        .vl_o      (cfg_vl)
    );

    simd_issue_decode u_simd_issue_decode (
        .issue_valid_i      (issue_valid_i),
        .op_i               (op_i),
        .src_i              (src_i),
        .use_mask_i         (use_mask_i),
        .dest_i             (dest_i),
        .vs1_i              (vs1_i),
        .vs2_i              (vs2_i),
        .old_vd_i           (old_vd_i),
        .mask_i             (mask_i),
        .rs1_i              (rs1_i),
        .imm_i              (imm_i),
        .sew_i              (cfg_sew),
        .vl_i               (cfg_vl),
        .ctrl_o             (ctrl),
        .opa_o              (opa),
        .opb_o              (opb),
        .alu_valid_o        (alu_valid),
        .mul_narrow_valid_o (mul_narrow_valid),
        .mul_wide_valid_o   (mul_wide_valid)
    );

    simd_alu u_simd_alu (
        .ctrl_i (ctrl),
        .opa_i  (opa),
        .opb_i  (opb),
        .uop_o  (alu_uop)
    );

    simd_mul u_simd_mul (
        .ctrl_i (ctrl),
        .opa_i  (opa),
        .opb_i  (opb),
        .uop_o  (mul_uop)
    );

    latency_pipe #(.DEPTH(1)) u_alu_pipe (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (alu_valid),
        .uop_i   (alu_uop),
        .valid_o (alu_done),
        .uop_o   (alu_done_uop)
    );

    // Both multiply pipes share the multiplier output
    latency_pipe #(.DEPTH(MUL_STAGES_NARROW)) u_mul_narrow_pipe (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (mul_narrow_valid),
        .uop_i   (mul_uop),
        .valid_o (narrow_done),
        .uop_o   (narrow_done_uop)
    );

    latency_pipe #(.DEPTH(MUL_STAGES_WIDE)) u_mul_wide_pipe (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .valid_i (mul_wide_valid),
        .uop_i   (mul_uop),
        .valid_o (wide_done),
        .uop_o   (wide_done_uop)
    );

    simd_writeback u_simd_writeback (
        .alu_valid_i    (alu_done),
        .alu_uop_i      (alu_done_uop),
        .narrow_valid_i (narrow_done),
        .narrow_uop_i   (narrow_done_uop),
        .wide_valid_i   (wide_done),
        .wide_uop_i     (wide_done_uop),
        .vec_valid_o    (vec_valid_o),
        .scalar_valid_o (scalar_valid_o),
        .wb_dest_o      (wb_dest_o),
        .vec_data_o     (vec_data_o),
        .scalar_data_o  (scalar_data_o)
    );

endmodule

`default_nettype wire

/* hdl/simd_writeback.sv */
// Completion select, mask merge, tail fill, scalar extract and output valids
`timescale 1ns/1ns
`default_nettype none

module simd_writeback (
    input  logic                 alu_valid_i,
    input  simd_pkg::uop_t       alu_uop_i,
    input  logic                 narrow_valid_i,
    input  simd_pkg::uop_t       narrow_uop_i,
    input  logic                 wide_valid_i,
    input  simd_pkg::uop_t       wide_uop_i,
    output logic                 vec_valid_o,
    output logic                 scalar_valid_o,
    output simd_pkg::reg_idx_t   wb_dest_o,
    output simd_pkg::vreg_t      vec_data_o,
    output simd_pkg::xlen_t      scalar_data_o
);

    simd_pkg::uop_t  sel_uop;
    logic            sel_valid;
    logic            is_scalar;
    simd_pkg::vreg_t res;
    simd_pkg::vreg_t old_vd;
    simd_pkg::vreg_t merged;
    simd_pkg::xlen_t elem0;

    // Deepest pipe wins on a collision
    assign sel_uop = wide_valid_i   ? wide_uop_i   :
                     narrow_valid_i ? narrow_uop_i : alu_uop_i;

    assign sel_valid = alu_valid_i || narrow_valid_i || wide_valid_i;
    assign is_scalar = (sel_uop.ctrl.op == simd_pkg::OP_VMV_X_S);
    assign res       = sel_uop.result;
    assign old_vd    = sel_uop.ctrl.old_vd;

    // Walk bytes and map each to its element index for mask and tail
    always_comb begin
        int idx;
        merged = '1;
        for (int i = 0; i < simd_pkg::VLEN/8; i++) begin
            idx = i >> sel_uop.ctrl.sew;
            if (idx < int'(sel_uop.ctrl.vl)) begin
                if (sel_uop.ctrl.use_mask && !sel_uop.ctrl.mask[idx]) begin
                    merged[i*8 +: 8] = old_vd[i*8 +: 8];   // Masked off
                end else begin
                    merged[i*8 +: 8] = res[i*8 +: 8];
                end
            end
        end
    end

    // Element 0 sign extended to scalar width
    always_comb begin
        case (sel_uop.ctrl.sew)
            simd_pkg::SEW_8:  elem0 = {{56{res[7]}}, res[7:0]};
            simd_pkg::SEW_16: elem0 = {{48{res[15]}}, res[15:0]};
            simd_pkg::SEW_32: elem0 = {{32{res[31]}}, res[31:0]};
            default:          elem0 = res[63:0];
        endcase
    end

    assign vec_valid_o    = sel_valid && !is_scalar && (sel_uop.ctrl.vl != '0);
    assign scalar_valid_o = sel_valid && is_scalar;
    assign wb_dest_o      = sel_uop.ctrl.dest;
    assign vec_data_o     = merged;
    assign scalar_data_o  = elem0;

endmodule

`default_nettype wire

/* hdl/simd_mul.sv */
// Per-element low-half multiply built from 64-bit lanes split by SEW
`timescale 1ns/1ns
`default_nettype none

module simd_mul (
    input  simd_pkg::uop_ctrl_t  ctrl_i,
    input  simd_pkg::vreg_t      opa_i,
    input  simd_pkg::vreg_t      opb_i,
    output simd_pkg::uop_t       uop_o
);

    localparam int LANES = simd_pkg::VLEN / simd_pkg::ELEN;

    simd_pkg::vreg_t res;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        simd_pkg::xlen_t lane_a;
        simd_pkg::xlen_t lane_b;
        simd_pkg::xlen_t lane_p;

        assign lane_a = opa_i[l*simd_pkg::ELEN +: simd_pkg::ELEN];
        assign lane_b = opb_i[l*simd_pkg::ELEN +: simd_pkg::ELEN];

        // Product width follows the element slice so only the low half is formed
        always_comb begin
            lane_p = '0;
            case (ctrl_i.sew)
                simd_pkg::SEW_8: begin
                    for (int k = 0; k < 8; k++) begin
                        lane_p[k*8 +: 8] = lane_a[k*8 +: 8] * lane_b[k*8 +: 8];
                    end
                end
                simd_pkg::SEW_16: begin
                    for (int k = 0; k < 4; k++) begin
                        lane_p[k*16 +: 16] = lane_a[k*16 +: 16] * lane_b[k*16 +: 16];
                    end
                end
                simd_pkg::SEW_32: begin
                    for (int k = 0; k < 2; k++) begin
                        lane_p[k*32 +: 32] = lane_a[k*32 +: 32] * lane_b[k*32 +: 32];
                    end
                end
                default: lane_p = lane_a * lane_b;  // Full lane at SEW 64
            endcase
        end

        assign res[l*simd_pkg::ELEN +: simd_pkg::ELEN] = lane_p;
    end

    assign uop_o.ctrl   = ctrl_i;
    assign uop_o.result = res;

endmodule

`default_nettype wire

/* hdl/simd_alu.sv */
// Per-element add, subtract, logic ops and vs2 pass for vmv.x.s at any SEW
`timescale 1ns/1ns
`default_nettype none

module simd_alu (
    input  simd_pkg::uop_ctrl_t  ctrl_i,
    input  simd_pkg::vreg_t      opa_i,
    input  simd_pkg::vreg_t      opb_i,
    output simd_pkg::uop_t       uop_o
);

    simd_pkg::vreg_t res;

    // Operands arrive zero extended and only the low SEW bits are kept
    function automatic simd_pkg::xlen_t elem_op(input simd_pkg::op_t   op,
                                                input simd_pkg::xlen_t a,
                                                input simd_pkg::xlen_t b);
        case (op)
            simd_pkg::OP_VADD: elem_op = b + a;
            simd_pkg::OP_VSUB: elem_op = b - a;
            simd_pkg::OP_VAND: elem_op = b & a;
            simd_pkg::OP_VOR:  elem_op = b | a;
            simd_pkg::OP_VXOR: elem_op = b ^ a;
            default:           elem_op = b;  // vmv.x.s reads vs2
        endcase
    endfunction

    always_comb begin
        simd_pkg::xlen_t tmp;
        res = '0;
        tmp = '0;
        case (ctrl_i.sew)
            simd_pkg::SEW_8: begin
                for (int i = 0; i < simd_pkg::VLEN/8; i++) begin
                    tmp = elem_op(ctrl_i.op, 64'(opa_i[i*8 +: 8]), 64'(opb_i[i*8 +: 8]));
                    res[i*8 +: 8] = tmp[7:0];
                end
            end
            simd_pkg::SEW_16: begin
                for (int i = 0; i < simd_pkg::VLEN/16; i++) begin
                    tmp = elem_op(ctrl_i.op, 64'(opa_i[i*16 +: 16]), 64'(opb_i[i*16 +: 16]));
                    res[i*16 +: 16] = tmp[15:0];
                end
            end
            simd_pkg::SEW_32: begin
                for (int i = 0; i < simd_pkg::VLEN/32; i++) begin
                    tmp = elem_op(ctrl_i.op, 64'(opa_i[i*32 +: 32]), 64'(opb_i[i*32 +: 32]));
                    res[i*32 +: 32] = tmp[31:0];
                end
            end
            default: begin
                for (int i = 0; i < simd_pkg::VLEN/64; i++) begin
                    res[i*64 +: 64] = elem_op(ctrl_i.op, opa_i[i*64 +: 64], opb_i[i*64 +: 64]);
                end
            end
        endcase
    end

    assign uop_o.ctrl   = ctrl_i;
    assign uop_o.result = res;

endmodule

`default_nettype wire

/* hdl/simd_issue_decode.sv */
// Issue decode with operand replication, control capture and pipe routing
`timescale 1ns/1ns
`default_nettype none

module simd_issue_decode (
    input  logic                 issue_valid_i,
    input  simd_pkg::op_t        op_i,
    input  simd_pkg::src_t       src_i,
    input  logic                 use_mask_i,
    input  simd_pkg::reg_idx_t   dest_i,
    input  simd_pkg::vreg_t      vs1_i,
    input  simd_pkg::vreg_t      vs2_i,
    input  simd_pkg::vreg_t      old_vd_i,
    input  simd_pkg::mask_t      mask_i,
    input  simd_pkg::xlen_t      rs1_i,
    input  logic [4:0]           imm_i,
    input  simd_pkg::sew_t       sew_i,
    input  simd_pkg::vl_t        vl_i,
    output simd_pkg::uop_ctrl_t  ctrl_o,
    output simd_pkg::vreg_t      opa_o,
    output simd_pkg::vreg_t      opb_o,
    output logic                 alu_valid_o,
    output logic                 mul_narrow_valid_o,
    output logic                 mul_wide_valid_o
);

    simd_pkg::xlen_t scalar_elem;
    simd_pkg::vreg_t scalar_rep;
    logic            is_mul;

    // Immediate goes out to 64 bits so any low slice is already sign extended
    assign scalar_elem = (src_i == simd_pkg::SRC_VX) ? rs1_i
                                                     : {{(simd_pkg::ELEN-5){imm_i[4]}}, imm_i};

    always_comb begin
        case (sew_i)
            simd_pkg::SEW_8:  scalar_rep = {(simd_pkg::VLEN/8){scalar_elem[7:0]}};
            simd_pkg::SEW_16: scalar_rep = {(simd_pkg::VLEN/16){scalar_elem[15:0]}};
            simd_pkg::SEW_32: scalar_rep = {(simd_pkg::VLEN/32){scalar_elem[31:0]}};
            default:          scalar_rep = {(simd_pkg::VLEN/64){scalar_elem}};
        endcase
    end

    assign opa_o = (src_i == simd_pkg::SRC_VV) ? vs1_i : scalar_rep;
    assign opb_o = vs2_i;

    assign ctrl_o.op       = op_i;
    assign ctrl_o.sew      = sew_i;   // Config as seen at issue time
    assign ctrl_o.vl       = vl_i;
    assign ctrl_o.use_mask = use_mask_i;
    assign ctrl_o.mask     = mask_i;
    assign ctrl_o.dest     = dest_i;
    assign ctrl_o.old_vd   = old_vd_i;

    // SEW 64 multiplies need the extra stage
    assign is_mul             = (op_i == simd_pkg::OP_VMUL);
    assign alu_valid_o        = issue_valid_i && !is_mul;
    assign mul_narrow_valid_o = issue_valid_i && is_mul && (sew_i != simd_pkg::SEW_64);
    assign mul_wide_valid_o   = issue_valid_i && is_mul && (sew_i == simd_pkg::SEW_64);

endmodule

`default_nettype wire

/* hdl/latency_pipe.sv */
// Fixed-depth shift register carrying a valid bit and a uop payload
`timescale 1ns/1ns
`default_nettype none

module latency_pipe #(
    parameter int DEPTH = 1
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            valid_i,
    input  simd_pkg::uop_t  uop_i,
    output logic            valid_o,
    output simd_pkg::uop_t  uop_o
);

    logic [DEPTH-1:0] valid_q;
    simd_pkg::uop_t   uop_q [DEPTH];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= valid_i;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload moves every cycle alongside its valid bit
    always_ff @(posedge clk_i) begin
        uop_q[0] <= uop_i;
        for (int i = 1; i < DEPTH; i++) begin
            uop_q[i] <= uop_q[i-1];
        end
    end

    assign valid_o = valid_q[DEPTH-1];
    assign uop_o   = uop_q[DEPTH-1];

endmodule

`default_nettype wire

/* hdl/vec_config_regs.sv */
// SEW and vl configuration registers with the requested length clamp
`timescale 1ns/1ns
`default_nettype none

module vec_config_regs (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 cfg_we_i,
    input  simd_pkg::avl_t       cfg_avl_i,
    input  simd_pkg::sew_t       cfg_sew_i,
    output simd_pkg::sew_t       sew_o,
    output simd_pkg::vl_t        vl_o
);

    simd_pkg::avl_t max_vl;
    simd_pkg::vl_t  vl_next;
    simd_pkg::sew_t sew_q;
    simd_pkg::vl_t  vl_q;

    // Elements per register halve with each SEW step
    assign max_vl = simd_pkg::avl_t'(simd_pkg::VLEN / 8) >> cfg_sew_i;

    assign vl_next = (cfg_avl_i > max_vl) ? simd_pkg::vl_t'(max_vl)
                                          : simd_pkg::vl_t'(cfg_avl_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_q <= simd_pkg::SEW_8;
            vl_q  <= '0;
        end else if (cfg_we_i) begin
            sew_q <= cfg_sew_i;
            vl_q  <= vl_next;
        end
    end

    assign sew_o = sew_q;
    assign vl_o  = vl_q;

endmodule

`default_nettype wire

/* hdl/simd_pkg.sv */
// Vector unit widths, element and op enums, uop control and payload structs
`default_nettype none

package simd_pkg;

    localparam int VLEN   = 128;
    localparam int ELEN   = 64;
    localparam int MASK_W = VLEN / 8;  // One bit per byte element

    typedef logic [VLEN-1:0]   vreg_t;
    typedef logic [ELEN-1:0]   xlen_t;
    typedef logic [4:0]        vl_t;     // 0 to VLEN/8 elements
    typedef logic [7:0]        avl_t;
    typedef logic [MASK_W-1:0] mask_t;
    typedef logic [4:0]        reg_idx_t;

    // Encoding is log2 of the element width in bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [1:0] {
        SRC_VV = 2'd0,
        SRC_VX = 2'd1,
        SRC_VI = 2'd2
    } src_t;

    typedef enum logic [2:0] {
        OP_VADD    = 3'd0,
        OP_VSUB    = 3'd1,
        OP_VAND    = 3'd2,
        OP_VOR     = 3'd3,
        OP_VXOR    = 3'd4,
        OP_VMUL    = 3'd5,
        OP_VMV_X_S = 3'd6
    } op_t;

    typedef struct packed {
        op_t      op;
        sew_t     sew;
        vl_t      vl;        // Captured at issue
        logic     use_mask;
        mask_t    mask;
        reg_idx_t dest;
        vreg_t    old_vd;
    } uop_ctrl_t;

    typedef struct packed {
        uop_ctrl_t ctrl;
        vreg_t     result;
    } uop_t;

endpackage

`default_nettype wire
